/* Makefile */
TOP := exec_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f exec_stage.f --top-module exec_stage
	verilator --lint-only --timing -f exec_stage.f --top-module $(TOP)

sim:
	verilator --binary --timing -f exec_stage.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* exec_stage.f */
+incdir+test
hdl/exec_pkg.sv
hdl/op_decode.sv
hdl/alu.sv
hdl/branch_resolver.sv
hdl/bit_unit.sv
hdl/mul_unit.sv
hdl/writeback_reg.sv
hdl/exec_stage.sv
test/exec_tb.sv

/* hdl/alu.sv */
// Integer ALU
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire exec_pkg::alu_op_t       alu_op_i,
    input  wire [exec_pkg::XLEN-1:0]     op_a_i,
    input  wire [exec_pkg::XLEN-1:0]     op_b_i,
    output logic [exec_pkg::XLEN-1:0]    result_o
);

    logic [exec_pkg::SHAMT_W-1:0] shamt;

    assign shamt = op_b_i[exec_pkg::SHAMT_W-1:0];              // Low five bits only

    always_comb begin
        case (alu_op_i)
            exec_pkg::ALU_ADD:  result_o = op_a_i + op_b_i;
            exec_pkg::ALU_SUB:  result_o = op_a_i - op_b_i;
            exec_pkg::ALU_AND:  result_o = op_a_i & op_b_i;
            exec_pkg::ALU_OR:   result_o = op_a_i | op_b_i;
            exec_pkg::ALU_XOR:  result_o = op_a_i ^ op_b_i;
            exec_pkg::ALU_SLL:  result_o = op_a_i << shamt;
            exec_pkg::ALU_SRL:  result_o = op_a_i >> shamt;
            exec_pkg::ALU_SRA:  result_o = $signed(op_a_i) >>> shamt; // Sign fill
            exec_pkg::ALU_SLT: begin
                result_o = exec_pkg::word_t'($signed(op_a_i) < $signed(op_b_i));
            end
            exec_pkg::ALU_SLTU: begin
                result_o = exec_pkg::word_t'(op_a_i < op_b_i);
            end
            default:            result_o = op_a_i + op_b_i;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/bit_unit.sv */
// Bit manipulation unit
`timescale 1ns/1ps
`default_nettype none

module bit_unit (
    input  wire exec_pkg::bit_op_t    bit_op_i,
    input  wire [exec_pkg::XLEN-1:0]  op_a_i,
    input  wire [exec_pkg::XLEN-1:0]  op_b_i,
    output logic [exec_pkg::XLEN-1:0] result_o
);

    typedef logic [exec_pkg::CNT_W-1:0] cnt_t;

    function automatic cnt_t popcount(input logic [exec_pkg::XLEN-1:0] v);
        cnt_t n;
        n = '0;
        for (int i = 0; i < exec_pkg::XLEN; i++) begin
            n = n + cnt_t'(v[i]);
        end
        return n;
    endfunction

    function automatic cnt_t trailing_zeros(input logic [exec_pkg::XLEN-1:0] v);
        cnt_t n;
        n = cnt_t'(exec_pkg::XLEN);                           // All-zero input
        for (int i = exec_pkg::XLEN - 1; i >= 0; i--) begin
            if (v[i]) begin
                n = cnt_t'(i);                                // Lowest set bit wins
            end
        end
        return n;
    endfunction

    always_comb begin
        case (bit_op_i)
            exec_pkg::BIT_RVRS:  result_o = {op_a_i[7:0], op_a_i[15:8],
                                             op_a_i[23:16], op_a_i[31:24]};
            exec_pkg::BIT_CNTZ:  result_o = exec_pkg::word_t'(trailing_zeros(op_a_i));
            exec_pkg::BIT_CNTP:  result_o = exec_pkg::word_t'(popcount(op_a_i));
            exec_pkg::BIT_PKG:   result_o = {op_b_i[15:0], op_a_i[15:0]};  // b on top
            exec_pkg::BIT_SLADD: result_o = (op_a_i << 1) + op_b_i;
            exec_pkg::BIT_HMDST: result_o = exec_pkg::word_t'(popcount(op_a_i ^ op_b_i));
            default:             result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/branch_resolver.sv */
// Branch condition evaluation
`timescale 1ns/1ps
`default_nettype none

module branch_resolver (
    input  wire exec_pkg::br_cond_t br_cond_i,
    input  wire [2:0]               cmp_i,      // {lt, ltu, eq} from decode
    output logic                    taken_o
);

    always_comb begin
        case (br_cond_i)
            exec_pkg::BR_EQ:     taken_o =  cmp_i[exec_pkg::CMP_EQ];
            exec_pkg::BR_NE:     taken_o = !cmp_i[exec_pkg::CMP_EQ];
            exec_pkg::BR_LT:     taken_o =  cmp_i[exec_pkg::CMP_LT];
            exec_pkg::BR_GE:     taken_o = !cmp_i[exec_pkg::CMP_LT];
            exec_pkg::BR_LTU:    taken_o =  cmp_i[exec_pkg::CMP_LTU];
            exec_pkg::BR_GEU:    taken_o = !cmp_i[exec_pkg::CMP_LTU];
            exec_pkg::BR_ALWAYS: taken_o = 1'b1;           // JAL and JALR
            // Strobe is sampled every cycle, so anything else stays quiet
            default:             taken_o = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/exec_pkg.sv */
// Execute stage definitions
`default_nettype none

package exec_pkg;

    localparam int XLEN        = 32;
    localparam int MUL_LATENCY = 2;                    // Issue to multiplier result
    localparam int SHAMT_W     = $clog2(XLEN);
    localparam int CNT_W       = $clog2(XLEN) + 1;     // Bit counts up to XLEN

    // Comparison flags arrive as {lt, ltu, eq}
    localparam int CMP_EQ  = 0;
    localparam int CMP_LTU = 1;
    localparam int CMP_LT  = 2;

    typedef logic [XLEN-1:0] word_t;

    typedef enum logic [5:0] {
        UOP_NOP    = 6'd0,
        UOP_ADD    = 6'd1,
        UOP_SUB    = 6'd2,
        UOP_AND    = 6'd3,
        UOP_OR     = 6'd4,
        UOP_XOR    = 6'd5,
        UOP_SLL    = 6'd6,
        UOP_SRL    = 6'd7,
        UOP_SRA    = 6'd8,
        UOP_SLT    = 6'd9,
        UOP_SLTU   = 6'd10,
        UOP_RVRS   = 6'd16,                            // Bit manipulation group
        UOP_CNTZ   = 6'd17,
        UOP_CNTP   = 6'd18,
        UOP_PKG    = 6'd19,
        UOP_SLADD  = 6'd20,
        UOP_HMDST  = 6'd21,
        UOP_MUL    = 6'd24,                            // Multiplier group
        UOP_MULH   = 6'd25,
        UOP_MULHSU = 6'd26,
        UOP_MULHU  = 6'd27,
        UOP_BEQ    = 6'd32,                            // Conditional branches
        UOP_BNE    = 6'd33,
        UOP_BLT    = 6'd34,
        UOP_BGE    = 6'd35,
        UOP_BLTU   = 6'd36,
        UOP_BGEU   = 6'd37,
        UOP_JAL    = 6'd40,
        UOP_JALR   = 6'd41
    } uop_t;

    typedef enum logic [2:0] {
        UNIT_NONE, UNIT_ALU, UNIT_BIT, UNIT_MUL, UNIT_LINK
    } unit_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_t;

    typedef enum logic [2:0] {
        BIT_RVRS, BIT_CNTZ, BIT_CNTP, BIT_PKG, BIT_SLADD, BIT_HMDST
    } bit_op_t;

    typedef enum logic [1:0] {
        MUL_LO, MUL_HSS, MUL_HSU, MUL_HUU              // Low word, then high word by signedness
    } mul_op_t;

    typedef enum logic [3:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_ALWAYS
    } br_cond_t;

endpackage

`default_nettype wire

/* hdl/exec_stage.sv */
// Execute stage top
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
    input  wire                        clk_i,
    input  wire                        rst_i,
    input  wire                        issue_valid_i,
    input  wire exec_pkg::uop_t        uop_i,
    input  wire [4:0]                  rd_i,
    input  wire [exec_pkg::XLEN-1:1]   pc_next_i,
    input  wire [exec_pkg::XLEN-1:0]   op_a_i,        // Forwarded, immediate already chosen
    input  wire [exec_pkg::XLEN-1:0]   op_b_i,
    input  wire [2:0]                  cmp_i,
    output logic [exec_pkg::XLEN-1:1]  jump_target_o,
    output logic                       jump_taken_o,
    output logic [exec_pkg::XLEN-1:0]  fwd_data_o,
    output logic                       wb_valid_o,
    output logic [4:0]                 wb_rd_o,
    output logic [exec_pkg::XLEN-1:0]  wb_data_o,
    output logic                       mul_valid_o,
    output logic [4:0]                 mul_rd_o,
    output logic [exec_pkg::XLEN-1:0]  mul_data_o
);

    exec_pkg::unit_t            unit;
    exec_pkg::alu_op_t          alu_op;
    exec_pkg::bit_op_t          bit_op;
    exec_pkg::mul_op_t          mul_op;
    exec_pkg::br_cond_t         br_cond;
    logic [exec_pkg::XLEN-1:0]  alu_result;
    logic [exec_pkg::XLEN-1:0]  bit_result;
    logic                       mul_start;

    op_decode u_decode (
        .issue_valid_i(issue_valid_i), .uop_i(uop_i), .unit_o(unit),
        .alu_op_o(alu_op), .bit_op_o(bit_op), .mul_op_o(mul_op), .br_cond_o(br_cond)
    );

    alu u_alu (
        .alu_op_i(alu_op), .op_a_i(op_a_i), .op_b_i(op_b_i), .result_o(alu_result)
    );

    branch_resolver u_branch (
        .br_cond_i(br_cond), .cmp_i(cmp_i), .taken_o(jump_taken_o)
    );

    assign jump_target_o = alu_result[exec_pkg::XLEN-1:1];   // pc+imm or rs1+imm

    bit_unit u_bit (
        .bit_op_i(bit_op), .op_a_i(op_a_i), .op_b_i(op_b_i), .result_o(bit_result)
    );

    assign mul_start = (unit == exec_pkg::UNIT_MUL);

    mul_unit u_mul (
        .clk_i(clk_i), .rst_i(rst_i), .start_i(mul_start), .mul_op_i(mul_op), .rd_i(rd_i),
        .op_a_i(op_a_i), .op_b_i(op_b_i),
        .valid_o(mul_valid_o), .rd_o(mul_rd_o), .result_o(mul_data_o)
    );

    writeback_reg u_wb (
        .clk_i(clk_i), .rst_i(rst_i), .unit_i(unit), .rd_i(rd_i), .pc_next_i(pc_next_i),
        .alu_result_i(alu_result), .bit_result_i(bit_result), .fwd_data_o(fwd_data_o),
        .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o)
    );

endmodule

`default_nettype wire

/* hdl/mul_unit.sv */
// Pipelined multiplier
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
    input  wire                        clk_i,
    input  wire                        rst_i,
    input  wire                        start_i,
    input  wire exec_pkg::mul_op_t     mul_op_i,
    input  wire [4:0]                  rd_i,
    input  wire [exec_pkg::XLEN-1:0]   op_a_i,
    input  wire [exec_pkg::XLEN-1:0]   op_b_i,
    output logic                       valid_o,
    output logic [4:0]                 rd_o,
    output logic [exec_pkg::XLEN-1:0]  result_o
);

    localparam int W = exec_pkg::XLEN;
    localparam int L = exec_pkg::MUL_LATENCY;

    logic                      sign_a;
    logic                      sign_b;
    logic signed [W:0]         a_q;                 // One extra bit for sign or zero
    logic signed [W:0]         b_q;
    exec_pkg::mul_op_t         op_q;
    logic signed [2*W+1:0]     product;
    logic [L-1:0]              valid_q;
    logic [L-1:0][4:0]         rd_q;

    // MUL keeps only the low word, so signedness does not matter there
    assign sign_a = (mul_op_i != exec_pkg::MUL_HUU);
    assign sign_b = (mul_op_i == exec_pkg::MUL_LO) || (mul_op_i == exec_pkg::MUL_HSS);

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            a_q  <= {sign_a & op_a_i[W-1], op_a_i};
            b_q  <= {sign_b & op_b_i[W-1], op_b_i};
            op_q <= mul_op_i;
        end
    end

    assign product = a_q * b_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
            rd_q    <= '0;
        end else begin
            valid_q <= {valid_q[L-2:0], start_i};   // Tag travels beside the data
            rd_q    <= {rd_q[L-2:0], rd_i};
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            result_o <= '0;
        end else if (valid_q[0]) begin
            result_o <= (op_q == exec_pkg::MUL_LO) ? product[W-1:0] : product[2*W-1:W];
        end
    end

    assign valid_o = valid_q[L-1];
    assign rd_o    = rd_q[L-1];

endmodule

`default_nettype wire

/* hdl/op_decode.sv */
// Micro-op decoder
`timescale 1ns/1ps
`default_nettype none

module op_decode (
    input  wire                  issue_valid_i,
    input  wire exec_pkg::uop_t  uop_i,
    output exec_pkg::unit_t      unit_o,
    output exec_pkg::alu_op_t    alu_op_o,
    output exec_pkg::bit_op_t    bit_op_o,
    output exec_pkg::mul_op_t    mul_op_o,
    output exec_pkg::br_cond_t   br_cond_o
);

    always_comb begin
        case (uop_i)
            exec_pkg::UOP_ADD, exec_pkg::UOP_SUB, exec_pkg::UOP_AND, exec_pkg::UOP_OR,
            exec_pkg::UOP_XOR, exec_pkg::UOP_SLL, exec_pkg::UOP_SRL, exec_pkg::UOP_SRA,
            exec_pkg::UOP_SLT, exec_pkg::UOP_SLTU:  unit_o = exec_pkg::UNIT_ALU;
            exec_pkg::UOP_RVRS, exec_pkg::UOP_CNTZ, exec_pkg::UOP_CNTP, exec_pkg::UOP_PKG,
            exec_pkg::UOP_SLADD, exec_pkg::UOP_HMDST: unit_o = exec_pkg::UNIT_BIT;
            exec_pkg::UOP_MUL, exec_pkg::UOP_MULH,
            exec_pkg::UOP_MULHSU, exec_pkg::UOP_MULHU: unit_o = exec_pkg::UNIT_MUL;
            exec_pkg::UOP_JAL, exec_pkg::UOP_JALR:   unit_o = exec_pkg::UNIT_LINK;
            default:                                 unit_o = exec_pkg::UNIT_NONE; // Branches too
        endcase

        case (uop_i)
            exec_pkg::UOP_SUB:  alu_op_o = exec_pkg::ALU_SUB;
            exec_pkg::UOP_AND:  alu_op_o = exec_pkg::ALU_AND;
            exec_pkg::UOP_OR:   alu_op_o = exec_pkg::ALU_OR;
            exec_pkg::UOP_XOR:  alu_op_o = exec_pkg::ALU_XOR;
            exec_pkg::UOP_SLL:  alu_op_o = exec_pkg::ALU_SLL;
            exec_pkg::UOP_SRL:  alu_op_o = exec_pkg::ALU_SRL;
            exec_pkg::UOP_SRA:  alu_op_o = exec_pkg::ALU_SRA;
            exec_pkg::UOP_SLT:  alu_op_o = exec_pkg::ALU_SLT;
            exec_pkg::UOP_SLTU: alu_op_o = exec_pkg::ALU_SLTU;
            default:            alu_op_o = exec_pkg::ALU_ADD; // Branch and jump targets
        endcase

        case (uop_i)
            exec_pkg::UOP_CNTZ:  bit_op_o = exec_pkg::BIT_CNTZ;
            exec_pkg::UOP_CNTP:  bit_op_o = exec_pkg::BIT_CNTP;
            exec_pkg::UOP_PKG:   bit_op_o = exec_pkg::BIT_PKG;
            exec_pkg::UOP_SLADD: bit_op_o = exec_pkg::BIT_SLADD;
            exec_pkg::UOP_HMDST: bit_op_o = exec_pkg::BIT_HMDST;
            default:             bit_op_o = exec_pkg::BIT_RVRS;
        endcase

        case (uop_i)
            exec_pkg::UOP_MULH:   mul_op_o = exec_pkg::MUL_HSS;
            exec_pkg::UOP_MULHSU: mul_op_o = exec_pkg::MUL_HSU;
            exec_pkg::UOP_MULHU:  mul_op_o = exec_pkg::MUL_HUU;
            default:              mul_op_o = exec_pkg::MUL_LO;
        endcase

        case (uop_i)
            exec_pkg::UOP_BEQ:  br_cond_o = exec_pkg::BR_EQ;
            exec_pkg::UOP_BNE:  br_cond_o = exec_pkg::BR_NE;
            exec_pkg::UOP_BLT:  br_cond_o = exec_pkg::BR_LT;
            exec_pkg::UOP_BGE:  br_cond_o = exec_pkg::BR_GE;
            exec_pkg::UOP_BLTU: br_cond_o = exec_pkg::BR_LTU;
            exec_pkg::UOP_BGEU: br_cond_o = exec_pkg::BR_GEU;
            exec_pkg::UOP_JAL, exec_pkg::UOP_JALR: br_cond_o = exec_pkg::BR_ALWAYS;
            default:            br_cond_o = exec_pkg::BR_NONE;
        endcase

        // An idle slot must neither write back nor redirect fetch
        if (!issue_valid_i) begin
            unit_o    = exec_pkg::UNIT_NONE;
            br_cond_o = exec_pkg::BR_NONE;
        end
    end

endmodule

`default_nettype wire

/* hdl/writeback_reg.sv */
// Result select and writeback registers
`timescale 1ns/1ps
`default_nettype none

module writeback_reg (
    input  wire                        clk_i,
    input  wire                        rst_i,
    input  wire exec_pkg::unit_t       unit_i,
    input  wire [4:0]                  rd_i,
    input  wire [exec_pkg::XLEN-1:1]   pc_next_i,
    input  wire [exec_pkg::XLEN-1:0]   alu_result_i,
    input  wire [exec_pkg::XLEN-1:0]   bit_result_i,
    output logic [exec_pkg::XLEN-1:0]  fwd_data_o,
    output logic                       wb_valid_o,
    output logic [4:0]                 wb_rd_o,
    output logic [exec_pkg::XLEN-1:0]  wb_data_o
);

    logic writes_rd;

    always_comb begin
        case (unit_i)
            exec_pkg::UNIT_ALU:  fwd_data_o = alu_result_i;
            exec_pkg::UNIT_BIT:  fwd_data_o = bit_result_i;
            exec_pkg::UNIT_LINK: fwd_data_o = {pc_next_i, 1'b0};   // Return address
            default:             fwd_data_o = '0;
        endcase
    end

    // Multiplies report on their own port, branches write nothing
    assign writes_rd = (unit_i == exec_pkg::UNIT_ALU) ||
                       (unit_i == exec_pkg::UNIT_BIT) ||
                       (unit_i == exec_pkg::UNIT_LINK);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_valid_o <= 1'b0;
            wb_rd_o    <= '0;
            wb_data_o  <= '0;
        end else begin
            wb_valid_o <= writes_rd;
            wb_rd_o    <= rd_i;
            wb_data_o  <= fwd_data_o;
        end
    end

endmodule

`default_nettype wire

/* test/exec_model.svh */
// Execute stage reference model
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

function automatic exec_pkg::word_t count_ones(input exec_pkg::word_t v);
    exec_pkg::word_t n;
    n = '0;
    for (int i = 0; i < exec_pkg::XLEN; i++) begin
        n = n + exec_pkg::word_t'(v[i]);
    end
    return n;
endfunction

function automatic exec_pkg::word_t count_trailing_zeros(input exec_pkg::word_t v);
    exec_pkg::word_t n;
    logic            seen;
    n    = '0;
    seen = 1'b0;
    for (int i = 0; i < exec_pkg::XLEN; i++) begin
        seen = seen | v[i];                               // Stop at the first one
        if (!seen) begin
            n = n + 1;
        end
    end
    return n;
endfunction

function automatic logic writes_register(input exec_pkg::uop_t u);
    return (u inside {exec_pkg::UOP_ADD, exec_pkg::UOP_SUB, exec_pkg::UOP_AND,
                      exec_pkg::UOP_OR, exec_pkg::UOP_XOR, exec_pkg::UOP_SLL,
                      exec_pkg::UOP_SRL, exec_pkg::UOP_SRA, exec_pkg::UOP_SLT,
                      exec_pkg::UOP_SLTU, exec_pkg::UOP_RVRS, exec_pkg::UOP_CNTZ,
                      exec_pkg::UOP_CNTP, exec_pkg::UOP_PKG, exec_pkg::UOP_SLADD,
                      exec_pkg::UOP_HMDST, exec_pkg::UOP_JAL, exec_pkg::UOP_JALR});
endfunction

function automatic logic is_multiply(input exec_pkg::uop_t u);
    return (u inside {exec_pkg::UOP_MUL, exec_pkg::UOP_MULH,
                      exec_pkg::UOP_MULHSU, exec_pkg::UOP_MULHU});
endfunction

function automatic logic branch_taken(input exec_pkg::uop_t u, input logic [2:0] cmp);
    case (u)
        exec_pkg::UOP_BEQ:  return cmp[exec_pkg::CMP_EQ];
        exec_pkg::UOP_BNE:  return !cmp[exec_pkg::CMP_EQ];
        exec_pkg::UOP_BLT:  return cmp[exec_pkg::CMP_LT];
        exec_pkg::UOP_BGE:  return !cmp[exec_pkg::CMP_LT];
        exec_pkg::UOP_BLTU: return cmp[exec_pkg::CMP_LTU];
        exec_pkg::UOP_BGEU: return !cmp[exec_pkg::CMP_LTU];
        exec_pkg::UOP_JAL, exec_pkg::UOP_JALR: return 1'b1;
        default:            return 1'b0;
    endcase
endfunction

function automatic exec_pkg::word_t expected_result(input exec_pkg::uop_t u,
        input exec_pkg::word_t a, input exec_pkg::word_t b,
        input logic [exec_pkg::XLEN-1:1] pc_next);
    case (u)
        exec_pkg::UOP_ADD:   return a + b;
        exec_pkg::UOP_SUB:   return a - b;
        exec_pkg::UOP_AND:   return a & b;
        exec_pkg::UOP_OR:    return a | b;
        exec_pkg::UOP_XOR:   return a ^ b;
        exec_pkg::UOP_SLL:   return a << b[4:0];
        exec_pkg::UOP_SRL:   return a >> b[4:0];
        exec_pkg::UOP_SRA:   return exec_pkg::word_t'($signed(a) >>> b[4:0]);
        exec_pkg::UOP_SLT:   return exec_pkg::word_t'($signed(a) < $signed(b));
        exec_pkg::UOP_SLTU:  return exec_pkg::word_t'(a < b);
        exec_pkg::UOP_RVRS:  return {a[7:0], a[15:8], a[23:16], a[31:24]};
        exec_pkg::UOP_CNTZ:  return count_trailing_zeros(a);
        exec_pkg::UOP_CNTP:  return count_ones(a);
        exec_pkg::UOP_PKG:   return {b[15:0], a[15:0]};
        exec_pkg::UOP_SLADD: return (a << 1) + b;
        exec_pkg::UOP_HMDST: return count_ones(a ^ b);
        exec_pkg::UOP_JAL, exec_pkg::UOP_JALR: return {pc_next, 1'b0};   // Link address
        default:             return '0;
    endcase
endfunction

function automatic exec_pkg::word_t multiply_result(input exec_pkg::uop_t u,
        input exec_pkg::word_t a, input exec_pkg::word_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] ua;
    logic signed [63:0] ub;
    logic signed [63:0] p;
    sa = {{32{a[31]}}, a};
    sb = {{32{b[31]}}, b};
    ua = {32'b0, a};
    ub = {32'b0, b};
    case (u)
        exec_pkg::UOP_MULHSU: p = sa * ub;                // Signed times unsigned
        exec_pkg::UOP_MULHU:  p = ua * ub;
        default:              p = sa * sb;
    endcase
    return (u == exec_pkg::UOP_MUL) ? p[31:0] : p[63:32];
endfunction

`endif

/* test/exec_tb.sv */
// Execute stage testbench
`timescale 1ns/1ps
`default_nettype none

module exec_tb;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 16;
    localparam int NUM_CYCLES      = 1600;
    localparam int NUM_UOPS        = 29;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_CYCLES + 384;   // About 2000

    typedef struct packed {
        exec_pkg::uop_t  uop;
        logic            valid;
        logic [4:0]      rd;
        exec_pkg::word_t data;
    } expect_t;

    logic                      clk_i;
    logic                      rst_i;
    logic                      issue_valid_i;
    exec_pkg::uop_t            uop_i;
    logic [4:0]                rd_i;
    logic [exec_pkg::XLEN-1:1] pc_next_i;
    exec_pkg::word_t           op_a_i;
    exec_pkg::word_t           op_b_i;
    logic [2:0]                cmp_i;
    logic [exec_pkg::XLEN-1:1] jump_target_o;
    logic                      jump_taken_o;
    exec_pkg::word_t           fwd_data_o;
    logic                      wb_valid_o;
    logic [4:0]                wb_rd_o;
    exec_pkg::word_t           wb_data_o;
    logic                      mul_valid_o;
    logic [4:0]                mul_rd_o;
    exec_pkg::word_t           mul_data_o;

    expect_t        wb_q[$];                              // One cycle deep
    expect_t        mul_q[$];                             // MUL_LATENCY deep
    exec_pkg::uop_t uop_table[NUM_UOPS];

    `include "exec_model.svh"

    exec_stage u_dut (
        .clk_i(clk_i), .rst_i(rst_i), .issue_valid_i(issue_valid_i), .uop_i(uop_i),
        .rd_i(rd_i), .pc_next_i(pc_next_i), .op_a_i(op_a_i), .op_b_i(op_b_i), .cmp_i(cmp_i),
        .jump_target_o(jump_target_o), .jump_taken_o(jump_taken_o), .fwd_data_o(fwd_data_o),
        .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o),
        .mul_valid_o(mul_valid_o), .mul_rd_o(mul_rd_o), .mul_data_o(mul_data_o)
    );

    initial clk_i = 1'b0;
    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_word(input string name, input exec_pkg::word_t exp,
                              input exec_pkg::word_t act);
        if (act !== exp) begin
            report_failure($sformatf("ERROR %s: expected 0x%08h, actual 0x%08h",
                                     name, exp, act));
        end
    endtask

    task automatic check_rd(input string name, input logic [4:0] exp, input logic [4:0] act);
        if (act !== exp) begin
            report_failure($sformatf("ERROR %s: expected x%0d, actual x%0d", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    function automatic string uop_label(input exec_pkg::uop_t u);
        string s;
        s = u.name();
        if (s == "") begin
            s = $sformatf("code_%0d", u);                 // Unlisted code
        end
        return s;
    endfunction

    function automatic exec_pkg::word_t pick_operand();
        case ($urandom % 8)
            0:       return '0;
            1:       return '1;
            2:       return 32'h8000_0000;                // Signed extremes
            3:       return 32'h7fff_ffff;
            default: return $urandom;
        endcase
    endfunction

    function automatic exec_pkg::uop_t pick_uop(input int cycle);
        int idx;
        idx = $urandom % NUM_UOPS;
        if (cycle % 100 < 20) begin                       // Back-to-back multiply burst
            return exec_pkg::uop_t'(6'(exec_pkg::UOP_MUL + $urandom % 4));
        end else if ($urandom % 32 == 0) begin
            return exec_pkg::uop_t'(6'($urandom));
        end
        return uop_table[idx];
    endfunction

    task automatic drive_cycle(input int cycle);
        issue_valid_i = ($urandom % 8) != 0;
        uop_i         = pick_uop(cycle);
        rd_i          = 5'($urandom);
        pc_next_i     = 31'($urandom);
        op_a_i        = pick_operand();
        op_b_i        = pick_operand();
        cmp_i         = 3'($urandom);
        if (cycle >= NUM_CYCLES - exec_pkg::MUL_LATENCY) begin
            issue_valid_i = 1'b0;                         // Drain the pipeline
        end
    endtask

    task automatic check_registered();
        expect_t e;
        if (wb_q.size() > 0) begin
            e = wb_q.pop_front();
            check_bit({uop_label(e.uop), " wb_valid"}, e.valid, wb_valid_o);
            if (e.valid) begin
                check_rd({uop_label(e.uop), " wb_rd"}, e.rd, wb_rd_o);
                check_word({uop_label(e.uop), " wb_data"}, e.data, wb_data_o);
            end
        end
        if (mul_q.size() == exec_pkg::MUL_LATENCY) begin
            e = mul_q.pop_front();
            check_bit({uop_label(e.uop), " mul_valid"}, e.valid, mul_valid_o);
            if (e.valid) begin
                check_rd({uop_label(e.uop), " mul_rd"}, e.rd, mul_rd_o);
                check_word({uop_label(e.uop), " mul_data"}, e.data, mul_data_o);
            end
        end
    endtask

    task automatic check_combinational();
        expect_t         wb_e;
        expect_t         mul_e;
        logic            taken;
        exec_pkg::word_t sum;
        string           label;
        label       = uop_label(uop_i);
        taken       = issue_valid_i && branch_taken(uop_i, cmp_i);
        sum         = op_a_i + op_b_i;                    // Target without bit 0
        wb_e.uop    = uop_i;
        wb_e.valid  = issue_valid_i && writes_register(uop_i);
        wb_e.rd     = rd_i;
        wb_e.data   = expected_result(uop_i, op_a_i, op_b_i, pc_next_i);
        mul_e.uop   = uop_i;
        mul_e.valid = issue_valid_i && is_multiply(uop_i);
        mul_e.rd    = rd_i;
        mul_e.data  = multiply_result(uop_i, op_a_i, op_b_i);
        check_bit({label, " jump_taken"}, taken, jump_taken_o);
        if (taken) begin
            check_word({label, " jump_target"}, {sum[31:1], 1'b0}, {jump_target_o, 1'b0});
        end
        if (wb_e.valid) begin
            check_word({label, " fwd_data"}, wb_e.data, fwd_data_o);
        end
        wb_q.push_back(wb_e);
        mul_q.push_back(mul_e);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure("Watchdog expired before the test finished");
    end

    initial begin
        void'($urandom(33));
        uop_table = '{exec_pkg::UOP_NOP, exec_pkg::UOP_ADD, exec_pkg::UOP_SUB,
                      exec_pkg::UOP_AND, exec_pkg::UOP_OR, exec_pkg::UOP_XOR,
                      exec_pkg::UOP_SLL, exec_pkg::UOP_SRL, exec_pkg::UOP_SRA,
                      exec_pkg::UOP_SLT, exec_pkg::UOP_SLTU, exec_pkg::UOP_RVRS,
                      exec_pkg::UOP_CNTZ, exec_pkg::UOP_CNTP, exec_pkg::UOP_PKG,
                      exec_pkg::UOP_SLADD, exec_pkg::UOP_HMDST, exec_pkg::UOP_MUL,
                      exec_pkg::UOP_MULH, exec_pkg::UOP_MULHSU, exec_pkg::UOP_MULHU,
                      exec_pkg::UOP_BEQ, exec_pkg::UOP_BNE, exec_pkg::UOP_BLT,
                      exec_pkg::UOP_BGE, exec_pkg::UOP_BLTU, exec_pkg::UOP_BGEU,
                      exec_pkg::UOP_JAL, exec_pkg::UOP_JALR};
        rst_i         = 1'b1;
        issue_valid_i = 1'b0;
        uop_i         = exec_pkg::UOP_NOP;
        rd_i          = '0;
        pc_next_i     = '0;
        op_a_i        = '0;
        op_b_i        = '0;
        cmp_i         = '0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;
        check_bit("reset wb_valid", 1'b0, wb_valid_o);    // Nothing issued yet
        check_bit("reset mul_valid", 1'b0, mul_valid_o);
        check_rd("reset wb_rd", '0, wb_rd_o);
        check_word("reset wb_data", '0, wb_data_o);
        check_word("reset mul_data", '0, mul_data_o);
        for (int cycle = 0; cycle < NUM_CYCLES; cycle++) begin
            check_registered();
            drive_cycle(cycle);
            #1;
            check_combinational();
            @(negedge clk_i);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire
